// File: dispatchPkg.sv
// Dispatch stage shared definitions

package dispatchPkg;

  // Machine widths
  localparam int DispatchWidth  = 4;  // Lanes per cycle
  localparam int Checkpoints    = 4;
  localparam int CheckpointsLog = 2;

  // Field widths
  localparam int PhysRegLog  = 7;
  localparam int LogRegLog   = 5;
  localparam int ImmWidth    = 16;
  localparam int OpcodeWidth = 8;
  localparam int PcWidth     = 32;

  // Back-end capacities, load and store queues share one size
  localparam int LsqSize        = 16;
  localparam int IssueQSize     = 32;
  localparam int ActiveListSize = 64;

  // Occupancy counters hold 0 up to the full size
  localparam int LsqCntWidth        = $clog2(LsqSize) + 1;
  localparam int IssueQCntWidth     = $clog2(IssueQSize) + 1;
  localparam int ActiveListCntWidth = $clog2(ActiveListSize) + 1;

  // Per-group load or store count, 0 to DispatchWidth
  localparam int LaneCntWidth = $clog2(DispatchWidth + 1);

  // One extra bit so count plus incoming never wraps
  localparam int LsqSumWidth        = LsqCntWidth + 1;
  localparam int IssueQSumWidth     = IssueQCntWidth + 1;
  localparam int ActiveListSumWidth = ActiveListCntWidth + 1;

  typedef logic [Checkpoints-1:0] branchMaskT;

  // Rename to dispatch packet, logDest on top
  typedef struct packed {
    logic [LogRegLog-1:0]      logDest;
    logic                      ctrlFlag;    // Branch or jump
    logic                      isStore;
    logic                      isLoad;
    branchMaskT                branchMask;  // Unresolved branches ahead
    logic [CheckpointsLog-1:0] checkpointId;
    logic [PhysRegLog-1:0]     phySrc1;
    logic [PhysRegLog-1:0]     phySrc2;
    logic [PhysRegLog-1:0]     phyDest;
    logic [PhysRegLog-1:0]     phyOldDest;  // Freed at retire
    logic [ImmWidth-1:0]       imm;
    logic [OpcodeWidth-1:0]    opcode;
    logic [PcWidth-1:0]        pc;
  } renamedPacketT;

  // Issue queue entry, renamed packet without logDest
  typedef struct packed {
    logic                      ctrlFlag;
    logic                      isStore;
    logic                      isLoad;
    branchMaskT                branchMask;  // Already updated for this cycle
    logic [CheckpointsLog-1:0] checkpointId;
    logic [PhysRegLog-1:0]     phySrc1;
    logic [PhysRegLog-1:0]     phySrc2;
    logic [PhysRegLog-1:0]     phyDest;
    logic [PhysRegLog-1:0]     phyOldDest;
    logic [ImmWidth-1:0]       imm;
    logic [OpcodeWidth-1:0]    opcode;
    logic [PcWidth-1:0]        pc;
  } issueqPacketT;

  // Active list entry, what retire and recovery need
  typedef struct packed {
    logic                  isLoad;
    logic                  isStore;
    logic [PcWidth-1:0]    pc;
    logic [LogRegLog-1:0]  logDest;
    logic [PhysRegLog-1:0] phyDest;
    logic [PhysRegLog-1:0] phyOldDest;
    logic                  ctrlFlag;
  } alPacketT;

  // Load-store queue entry
  typedef struct packed {
    branchMaskT branchMask;
    logic       isStore;
    logic       isLoad;
  } lsqPacketT;

endpackage

// File: laneFormer.sv
// Dispatch lane packet former

`timescale 1ns/1ps

module laneFormer (
  input  dispatchPkg::renamedPacketT              renamedPacket_i,
  input  logic                                    ctrlVerified_i,
  input  logic [dispatchPkg::CheckpointsLog-1:0]  ctrlVerifiedId_i,

  output dispatchPkg::issueqPacketT               issueqPacket_o,
  output dispatchPkg::alPacketT                   alPacket_o,
  output dispatchPkg::lsqPacketT                  lsqPacket_o,
  output dispatchPkg::branchMaskT                 updatedBranchMask_o,
  output logic                                    load_o,
  output logic                                    store_o
);

  dispatchPkg::branchMaskT clearMask;   // One-hot bit of the verified branch
  dispatchPkg::branchMaskT laneMask;    // Mask after the clear

  // A verified branch no longer guards younger instructions
  always_comb
  begin
    if (ctrlVerified_i)
    begin
      clearMask = dispatchPkg::branchMaskT'(1) << ctrlVerifiedId_i;
    end
    else
    begin
      clearMask = '0;
    end
  end

  assign laneMask = renamedPacket_i.branchMask & ~clearMask;

  // Goes back to the rename/dispatch register in case of a stall
  assign updatedBranchMask_o = laneMask;

  // Flags for the load and store counters
  assign load_o  = renamedPacket_i.isLoad;
  assign store_o = renamedPacket_i.isStore;

  // Issue queue packet
  always_comb
  begin
    issueqPacket_o.ctrlFlag     = renamedPacket_i.ctrlFlag;
    issueqPacket_o.isStore      = renamedPacket_i.isStore;
    issueqPacket_o.isLoad       = renamedPacket_i.isLoad;
    issueqPacket_o.branchMask   = laneMask;
    issueqPacket_o.checkpointId = renamedPacket_i.checkpointId;
    issueqPacket_o.phySrc1      = renamedPacket_i.phySrc1;
    issueqPacket_o.phySrc2      = renamedPacket_i.phySrc2;
    issueqPacket_o.phyDest      = renamedPacket_i.phyDest;
    issueqPacket_o.phyOldDest   = renamedPacket_i.phyOldDest;
    issueqPacket_o.imm          = renamedPacket_i.imm;
    issueqPacket_o.opcode       = renamedPacket_i.opcode;
    issueqPacket_o.pc           = renamedPacket_i.pc;
  end

  // Active list keeps the mapping to undo or commit
  always_comb
  begin
    alPacket_o.isLoad     = renamedPacket_i.isLoad;
    alPacket_o.isStore    = renamedPacket_i.isStore;
    alPacket_o.pc         = renamedPacket_i.pc;
    alPacket_o.logDest    = renamedPacket_i.logDest;
    alPacket_o.phyDest    = renamedPacket_i.phyDest;
    alPacket_o.phyOldDest = renamedPacket_i.phyOldDest;  // Released at commit
    alPacket_o.ctrlFlag   = renamedPacket_i.ctrlFlag;
  end

  // LSQ only needs the mask for squash and the type
  always_comb
  begin
    lsqPacket_o.branchMask = laneMask;
    lsqPacket_o.isStore    = renamedPacket_i.isStore;
    lsqPacket_o.isLoad     = renamedPacket_i.isLoad;
  end

endmodule

// File: spaceCheck.sv
// Back-end space check

`timescale 1ns/1ps

module spaceCheck (
  input  logic                                        load0_i,
  input  logic                                        load1_i,
  input  logic                                        load2_i,
  input  logic                                        load3_i,
  input  logic                                        store0_i,
  input  logic                                        store1_i,
  input  logic                                        store2_i,
  input  logic                                        store3_i,

  input  logic [dispatchPkg::LsqCntWidth-1:0]         loadQueueCnt_i,
  input  logic [dispatchPkg::LsqCntWidth-1:0]         storeQueueCnt_i,
  input  logic [dispatchPkg::IssueQCntWidth-1:0]      issueQueueCnt_i,
  input  logic [dispatchPkg::ActiveListCntWidth-1:0]  activeListCnt_i,

  input  logic                                        renameReady_i,
  input  logic                                        flagRecoverEx_i,

  output logic                                        backEndReady_o,
  output logic                                        stallFrontEnd_o
);

  logic [dispatchPkg::LaneCntWidth-1:0]       loadCnt;
  logic [dispatchPkg::LaneCntWidth-1:0]       storeCnt;

  logic [dispatchPkg::LsqSumWidth-1:0]        loadSum;
  logic [dispatchPkg::LsqSumWidth-1:0]        storeSum;
  logic [dispatchPkg::IssueQSumWidth-1:0]     issueSum;
  logic [dispatchPkg::ActiveListSumWidth-1:0] activeSum;

  logic loadFull;
  logic storeFull;
  logic issueFull;
  logic activeFull;

  // Loads and stores in this group
  assign loadCnt  = dispatchPkg::LaneCntWidth'(load0_i) + dispatchPkg::LaneCntWidth'(load1_i)
                  + dispatchPkg::LaneCntWidth'(load2_i) + dispatchPkg::LaneCntWidth'(load3_i);
  assign storeCnt = dispatchPkg::LaneCntWidth'(store0_i) + dispatchPkg::LaneCntWidth'(store1_i)
                  + dispatchPkg::LaneCntWidth'(store2_i) + dispatchPkg::LaneCntWidth'(store3_i);

  // LSQ only takes the memory ops
  assign loadSum  = dispatchPkg::LsqSumWidth'(loadQueueCnt_i)
                  + dispatchPkg::LsqSumWidth'(loadCnt);
  assign storeSum = dispatchPkg::LsqSumWidth'(storeQueueCnt_i)
                  + dispatchPkg::LsqSumWidth'(storeCnt);

  // Issue queue and active list take every lane
  assign issueSum  = dispatchPkg::IssueQSumWidth'(issueQueueCnt_i)
                   + dispatchPkg::IssueQSumWidth'(dispatchPkg::DispatchWidth);
  assign activeSum = dispatchPkg::ActiveListSumWidth'(activeListCnt_i)
                   + dispatchPkg::ActiveListSumWidth'(dispatchPkg::DispatchWidth);

  assign loadFull   = loadSum > dispatchPkg::LsqSumWidth'(dispatchPkg::LsqSize);
  assign storeFull  = storeSum > dispatchPkg::LsqSumWidth'(dispatchPkg::LsqSize);
  assign issueFull  = issueSum > dispatchPkg::IssueQSumWidth'(dispatchPkg::IssueQSize);
  assign activeFull = activeSum
                    > dispatchPkg::ActiveListSumWidth'(dispatchPkg::ActiveListSize);

  // Any overflow holds decode and rename
  assign stallFrontEnd_o = loadFull | storeFull | issueFull | activeFull;

  // No dispatch during recovery, packets would be squashed anyway
  assign backEndReady_o = ~stallFrontEnd_o & renameReady_i & ~flagRecoverEx_i;

endmodule

// File: dispatchTop.sv
// Four-wide dispatch stage

`timescale 1ns/1ps

module dispatchTop (
  input  dispatchPkg::renamedPacketT                  renamedPacket0_i,
  input  dispatchPkg::renamedPacketT                  renamedPacket1_i,
  input  dispatchPkg::renamedPacketT                  renamedPacket2_i,
  input  dispatchPkg::renamedPacketT                  renamedPacket3_i,

  input  logic                                        renameReady_i,    // Rename has a group
  input  logic                                        flagRecoverEx_i,
  input  logic                                        ctrlVerified_i,
  input  logic [dispatchPkg::CheckpointsLog-1:0]      ctrlVerifiedId_i,

  // Current back-end occupancy
  input  logic [dispatchPkg::LsqCntWidth-1:0]         loadQueueCnt_i,
  input  logic [dispatchPkg::LsqCntWidth-1:0]         storeQueueCnt_i,
  input  logic [dispatchPkg::IssueQCntWidth-1:0]      issueQueueCnt_i,
  input  logic [dispatchPkg::ActiveListCntWidth-1:0]  activeListCnt_i,

  output dispatchPkg::issueqPacketT                   issueqPacket0_o,
  output dispatchPkg::issueqPacketT                   issueqPacket1_o,
  output dispatchPkg::issueqPacketT                   issueqPacket2_o,
  output dispatchPkg::issueqPacketT                   issueqPacket3_o,

  output dispatchPkg::alPacketT                       alPacket0_o,
  output dispatchPkg::alPacketT                       alPacket1_o,
  output dispatchPkg::alPacketT                       alPacket2_o,
  output dispatchPkg::alPacketT                       alPacket3_o,

  output dispatchPkg::lsqPacketT                      lsqPacket0_o,
  output dispatchPkg::lsqPacketT                      lsqPacket1_o,
  output dispatchPkg::lsqPacketT                      lsqPacket2_o,
  output dispatchPkg::lsqPacketT                      lsqPacket3_o,

  // Back to the rename/dispatch register when the group is held
  output dispatchPkg::branchMaskT                     updatedBranchMask0_o,
  output dispatchPkg::branchMaskT                     updatedBranchMask1_o,
  output dispatchPkg::branchMaskT                     updatedBranchMask2_o,
  output dispatchPkg::branchMaskT                     updatedBranchMask3_o,

  output logic                                        backEndReady_o,
  output logic                                        stallFrontEnd_o
);

  // Per-lane memory op flags
  logic load0;
  logic load1;
  logic load2;
  logic load3;
  logic store0;
  logic store1;
  logic store2;
  logic store3;

  laneFormer lane0 (
    .renamedPacket_i     (renamedPacket0_i),
    .ctrlVerified_i      (ctrlVerified_i),
    .ctrlVerifiedId_i    (ctrlVerifiedId_i),
    .issueqPacket_o      (issueqPacket0_o),
    .alPacket_o          (alPacket0_o),
    .lsqPacket_o         (lsqPacket0_o),
    .updatedBranchMask_o (updatedBranchMask0_o),
    .load_o              (load0),
    .store_o             (store0)
  );

  laneFormer lane1 (
    .renamedPacket_i     (renamedPacket1_i),
    .ctrlVerified_i      (ctrlVerified_i),
    .ctrlVerifiedId_i    (ctrlVerifiedId_i),
    .issueqPacket_o      (issueqPacket1_o),
    .alPacket_o          (alPacket1_o),
    .lsqPacket_o         (lsqPacket1_o),
    .updatedBranchMask_o (updatedBranchMask1_o),
    .load_o              (load1),
    .store_o             (store1)
  );

  laneFormer lane2 (
    .renamedPacket_i     (renamedPacket2_i),
    .ctrlVerified_i      (ctrlVerified_i),
    .ctrlVerifiedId_i    (ctrlVerifiedId_i),
    .issueqPacket_o      (issueqPacket2_o),
    .alPacket_o          (alPacket2_o),
    .lsqPacket_o         (lsqPacket2_o),
    .updatedBranchMask_o (updatedBranchMask2_o),
    .load_o              (load2),
    .store_o             (store2)
  );

  laneFormer lane3 (
    .renamedPacket_i     (renamedPacket3_i),
    .ctrlVerified_i      (ctrlVerified_i),
    .ctrlVerifiedId_i    (ctrlVerifiedId_i),
    .issueqPacket_o      (issueqPacket3_o),
    .alPacket_o          (alPacket3_o),
    .lsqPacket_o         (lsqPacket3_o),
    .updatedBranchMask_o (updatedBranchMask3_o),
    .load_o              (load3),
    .store_o             (store3)
  );

  // Room check for the whole group
  spaceCheck space (
    .load0_i         (load0),
    .load1_i         (load1),
    .load2_i         (load2),
    .load3_i         (load3),
    .store0_i        (store0),
    .store1_i        (store1),
    .store2_i        (store2),
    .store3_i        (store3),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .renameReady_i   (renameReady_i),
    .flagRecoverEx_i (flagRecoverEx_i),
    .backEndReady_o  (backEndReady_o),
    .stallFrontEnd_o (stallFrontEnd_o)
  );

endmodule

// File: tbDispatchChecks.svh
// Dispatch reference model and checks

`ifndef TB_DISPATCH_CHECKS_SVH
`define TB_DISPATCH_CHECKS_SVH

// A verified branch drops out of every mask
function automatic dispatchPkg::branchMaskT maskModel(input dispatchPkg::branchMaskT m);
  dispatchPkg::branchMaskT res;
  for (int i = 0; i < dispatchPkg::Checkpoints; i++)
  begin
    res[i] = m[i] && !(ctrlVerified && int'(ctrlVerifiedId) == i);
  end
  return res;
endfunction

function automatic dispatchPkg::issueqPacketT issueModel(
  input dispatchPkg::renamedPacketT p
);
  dispatchPkg::issueqPacketT q;
  q.ctrlFlag     = p.ctrlFlag;
  q.isStore      = p.isStore;
  q.isLoad       = p.isLoad;
  q.branchMask   = maskModel(p.branchMask);
  q.checkpointId = p.checkpointId;
  q.phySrc1      = p.phySrc1;
  q.phySrc2      = p.phySrc2;
  q.phyDest      = p.phyDest;
  q.phyOldDest   = p.phyOldDest;
  q.imm          = p.imm;
  q.opcode       = p.opcode;
  q.pc           = p.pc;
  return q;
endfunction

function automatic dispatchPkg::alPacketT alModel(input dispatchPkg::renamedPacketT p);
  dispatchPkg::alPacketT a;
  a.isLoad     = p.isLoad;
  a.isStore    = p.isStore;
  a.pc         = p.pc;
  a.logDest    = p.logDest;
  a.phyDest    = p.phyDest;
  a.phyOldDest = p.phyOldDest;
  a.ctrlFlag   = p.ctrlFlag;
  return a;
endfunction

// Overflow of any queue with the whole group added
function automatic logic stallModel();
  int loads;
  int stores;
  loads  = 0;
  stores = 0;
  for (int lane = 0; lane < dispatchPkg::DispatchWidth; lane++)
  begin
    loads  += int'(renamed[lane].isLoad);
    stores += int'(renamed[lane].isStore);
  end
  return (int'(loadQueueCnt) + loads > dispatchPkg::LsqSize)
      || (int'(storeQueueCnt) + stores > dispatchPkg::LsqSize)
      || (int'(issueQueueCnt) + dispatchPkg::DispatchWidth > dispatchPkg::IssueQSize)
      || (int'(activeListCnt) + dispatchPkg::DispatchWidth > dispatchPkg::ActiveListSize);
endfunction

task automatic reportValue(input string name, input logic [127:0] expVal,
                           input logic [127:0] gotVal);
  testErrors++;
  $display("Fail %s expected 0x%0h got 0x%0h at time %0t", name, expVal, gotVal, $time);
endtask

task automatic checkOutputs();
  dispatchPkg::issueqPacketT iqExp;
  dispatchPkg::alPacketT     alExp;
  dispatchPkg::lsqPacketT    lsqExp;
  dispatchPkg::branchMaskT   maskExp;
  logic                      stallExp;
  logic                      readyExp;
  for (int lane = 0; lane < dispatchPkg::DispatchWidth; lane++)
  begin
    maskExp = maskModel(renamed[lane].branchMask);
    iqExp   = issueModel(renamed[lane]);
    alExp   = alModel(renamed[lane]);
    lsqExp  = {maskExp, renamed[lane].isStore, renamed[lane].isLoad};
    assert (maskOut[lane] === maskExp)
      else reportValue($sformatf("updatedBranchMask%0d_o", lane), 128'(maskExp),
                       128'(maskOut[lane]));
    assert (iqOut[lane] === iqExp)
      else reportValue($sformatf("issueqPacket%0d_o", lane), 128'(iqExp), 128'(iqOut[lane]));
    assert (alOut[lane] === alExp)
      else reportValue($sformatf("alPacket%0d_o", lane), 128'(alExp), 128'(alOut[lane]));
    assert (lsqOut[lane] === lsqExp)
      else reportValue($sformatf("lsqPacket%0d_o", lane), 128'(lsqExp), 128'(lsqOut[lane]));
  end
  stallExp = stallModel();
  readyExp = !stallExp && renameReady && !flagRecoverEx;  // Recovery blocks dispatch
  assert (stallFrontEnd === stallExp)
    else reportValue("stallFrontEnd_o", 128'(stallExp), 128'(stallFrontEnd));
  assert (backEndReady === readyExp)
    else reportValue("backEndReady_o", 128'(readyExp), 128'(backEndReady));
endtask

`endif

// File: tbDispatch.sv
// Dispatch stage testbench

`timescale 1ns/1ps

module tbDispatch;

  localparam int ClkPeriod   = 40;
  localparam int DriveDelay  = 2;
  localparam int CheckDelay  = ClkPeriod - DriveDelay - 2;  // Sample 2 ns before the edge
  localparam int ResetCycles = 8;
  localparam int Seed        = 32'h0588_2eb3;

  // Cycles spent in each test
  localparam int MapCycles   = 40;
  localparam int MaskCycles  = 40;
  localparam int LsqCycles   = 64;
  localparam int SweepCycles = dispatchPkg::IssueQSize + dispatchPkg::ActiveListSize + 2;
  localparam int ReadyCycles = 80;
  localparam int TotalCycles = ResetCycles + MapCycles + MaskCycles + LsqCycles
                             + SweepCycles + ReadyCycles;
  localparam int TimeoutNs   = TotalCycles * ClkPeriod + 20 * ClkPeriod;

  logic clk;
  logic rstN_i;

  // DUT inputs
  dispatchPkg::renamedPacketT renamed [dispatchPkg::DispatchWidth];
  logic                                       renameReady;
  logic                                       flagRecoverEx;
  logic                                       ctrlVerified;
  logic [dispatchPkg::CheckpointsLog-1:0]     ctrlVerifiedId;
  logic [dispatchPkg::LsqCntWidth-1:0]        loadQueueCnt;
  logic [dispatchPkg::LsqCntWidth-1:0]        storeQueueCnt;
  logic [dispatchPkg::IssueQCntWidth-1:0]     issueQueueCnt;
  logic [dispatchPkg::ActiveListCntWidth-1:0] activeListCnt;

  // DUT outputs per lane
  dispatchPkg::issueqPacketT iqOut   [dispatchPkg::DispatchWidth];
  dispatchPkg::alPacketT     alOut   [dispatchPkg::DispatchWidth];
  dispatchPkg::lsqPacketT    lsqOut  [dispatchPkg::DispatchWidth];
  dispatchPkg::branchMaskT   maskOut [dispatchPkg::DispatchWidth];
  logic                      backEndReady;
  logic                      stallFrontEnd;

  int testErrors;
  int testsPassed;
  int testsFailed;

  dispatchTop UUT (
    .renamedPacket0_i     (renamed[0]),
    .renamedPacket1_i     (renamed[1]),
    .renamedPacket2_i     (renamed[2]),
    .renamedPacket3_i     (renamed[3]),
    .renameReady_i        (renameReady),
    .flagRecoverEx_i      (flagRecoverEx),
    .ctrlVerified_i       (ctrlVerified),
    .ctrlVerifiedId_i     (ctrlVerifiedId),
    .loadQueueCnt_i       (loadQueueCnt),
    .storeQueueCnt_i      (storeQueueCnt),
    .issueQueueCnt_i      (issueQueueCnt),
    .activeListCnt_i      (activeListCnt),
    .issueqPacket0_o      (iqOut[0]),
    .issueqPacket1_o      (iqOut[1]),
    .issueqPacket2_o      (iqOut[2]),
    .issueqPacket3_o      (iqOut[3]),
    .alPacket0_o          (alOut[0]),
    .alPacket1_o          (alOut[1]),
    .alPacket2_o          (alOut[2]),
    .alPacket3_o          (alOut[3]),
    .lsqPacket0_o         (lsqOut[0]),
    .lsqPacket1_o         (lsqOut[1]),
    .lsqPacket2_o         (lsqOut[2]),
    .lsqPacket3_o         (lsqOut[3]),
    .updatedBranchMask0_o (maskOut[0]),
    .updatedBranchMask1_o (maskOut[1]),
    .updatedBranchMask2_o (maskOut[2]),
    .updatedBranchMask3_o (maskOut[3]),
    .backEndReady_o       (backEndReady),
    .stallFrontEnd_o      (stallFrontEnd)
  );

  `include "tbDispatchChecks.svh"

  initial
  begin
    clk = 1'b0;
  end

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic clearInputs();
    for (int lane = 0; lane < dispatchPkg::DispatchWidth; lane++)
    begin
      renamed[lane] = '0;
    end
    renameReady    = 1'b0;
    flagRecoverEx  = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlVerifiedId = '0;
    loadQueueCnt   = '0;
    storeQueueCnt  = '0;
    issueQueueCnt  = '0;
    activeListCnt  = '0;
  endtask

  function automatic dispatchPkg::renamedPacketT drawPacket();
    logic [127:0] raw;
    raw = {$urandom(), $urandom(), $urandom(), $urandom()};
    return raw[$bits(dispatchPkg::renamedPacketT)-1:0];
  endfunction

  // New group of random packets with the memory type picked per lane
  task automatic fillGroup(input bit memOps);
    int kind;
    for (int lane = 0; lane < dispatchPkg::DispatchWidth; lane++)
    begin
      renamed[lane] = drawPacket();
      kind = int'($urandom % 3);
      renamed[lane].isLoad  = memOps && kind == 1;
      renamed[lane].isStore = memOps && kind == 2;
    end
  endtask

  task automatic beginCycle();
    @(posedge clk);
    #DriveDelay;
  endtask

  task automatic endCycle();
    #CheckDelay;
    checkOutputs();
  endtask

  task automatic finishTest(input string name);
    if (testErrors == 0)
    begin
      testsPassed++;
      $display("Test %s done, no errors", name);
    end
    else
    begin
      testsFailed++;
      $display("Test %s done, %0d errors", name, testErrors);
    end
    testErrors = 0;
  endtask

  // Plain mapping with no verify and an empty back end
  task automatic mapTest();
    for (int n = 0; n < MapCycles; n++)
    begin
      beginCycle();
      fillGroup(1'b1);
      ctrlVerified = 1'b0;
      renameReady  = 1'b1;
      endCycle();
    end
    finishTest("packet mapping");
  endtask

  task automatic maskTest();
    for (int n = 0; n < MaskCycles; n++)
    begin
      beginCycle();
      fillGroup(1'b1);
      ctrlVerified   = 1'b1;
      ctrlVerifiedId = dispatchPkg::CheckpointsLog'($urandom % dispatchPkg::Checkpoints);
      endCycle();
    end
    finishTest("branch mask clear");
  endtask

  // Queue counts within one group of full
  task automatic lsqTest();
    for (int n = 0; n < LsqCycles; n++)
    begin
      beginCycle();
      fillGroup(1'b1);
      ctrlVerified  = 1'($urandom);
      loadQueueCnt  = dispatchPkg::LsqCntWidth'(dispatchPkg::LsqSize
                    - dispatchPkg::DispatchWidth + int'($urandom % 5));
      storeQueueCnt = dispatchPkg::LsqCntWidth'(dispatchPkg::LsqSize
                    - dispatchPkg::DispatchWidth + int'($urandom % 5));
      endCycle();
    end
    finishTest("load store capacity");
  endtask

  // Full sweep crosses size minus DispatchWidth and one above
  task automatic sweepTest();
    for (int cnt = 0; cnt <= dispatchPkg::IssueQSize; cnt++)
    begin
      beginCycle();
      fillGroup(1'b0);
      loadQueueCnt  = '0;  // Empty LSQ so only the issue queue can stall
      storeQueueCnt = '0;
      issueQueueCnt = dispatchPkg::IssueQCntWidth'(cnt);
      endCycle();
    end
    for (int cnt = 0; cnt <= dispatchPkg::ActiveListSize; cnt++)
    begin
      beginCycle();
      fillGroup(1'b0);
      issueQueueCnt = '0;
      activeListCnt = dispatchPkg::ActiveListCntWidth'(cnt);
      endCycle();
    end
    finishTest("issue queue and active list capacity");
  endtask

  task automatic readyTest();
    for (int n = 0; n < ReadyCycles; n++)
    begin
      beginCycle();
      fillGroup(1'b1);
      renameReady   = 1'($urandom);
      flagRecoverEx = 1'($urandom);
      ctrlVerified  = 1'($urandom);
      loadQueueCnt  = dispatchPkg::LsqCntWidth'($urandom % (dispatchPkg::LsqSize + 1));
      storeQueueCnt = dispatchPkg::LsqCntWidth'($urandom % (dispatchPkg::LsqSize + 1));
      issueQueueCnt = dispatchPkg::IssueQCntWidth'($urandom % (dispatchPkg::IssueQSize + 1));
      activeListCnt = dispatchPkg::ActiveListCntWidth'($urandom
                    % (dispatchPkg::ActiveListSize + 1));
      endCycle();
    end
    finishTest("ready level");
  endtask

  initial
  begin
    #(TimeoutNs);
    $display("Watchdog expired after %0d ns, tests did not complete", TimeoutNs);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    void'($urandom(Seed));
    testErrors  = 0;
    testsPassed = 0;
    testsFailed = 0;
    clearInputs();
    rstN_i = 1'b0;  // Inputs held at zero while in reset
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rstN_i = 1'b1;

    mapTest();
    maskTest();
    lsqTest();
    sweepTest();
    readyTest();

    $display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
    if (testsFailed == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+.
dispatchPkg.sv
laneFormer.sv
spaceCheck.sv
dispatchTop.sv
tbDispatch.sv

// File: Makefile
# Verilator flow for the dispatch stage

TOP = tbDispatch

all: sim

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps --top-module dispatchTop \
		dispatchPkg.sv laneFormer.sv spaceCheck.sv dispatchTop.sv

build:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f sim.f

sim: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all lint build sim clean
